//--- hdl/qla_pkg.sv
package qla_pkg;

    // ------------------------------
    // board dimensions
    // ------------------------------
    localparam int num_chan  = 4;    // motor axes, host sees them as 1..num_chan
    localparam int dac_width = 16;   // commanded current word
    localparam int adc_width = 16;   // one cur or pot conversion

    // motor status word, read side
    localparam int status_amp_on_bit = 29;   // amplifier enabled
    localparam int status_safety_bit = 17;   // sticky safety disable
    localparam int status_fault_bit  = 16;   // raw fault_n from op amp

    // motor status word, write side
    localparam int amp_en_mask_bit = 29;     // 1 -> apply the enable value
    localparam int amp_en_val_bit  = 28;     // requested amp state

    // ------------------------------
    // address map
    // ------------------------------

    // top nibble of the bus address, only main is decoded here
    typedef enum logic [3:0] {
        space_main = 4'h0
    } addr_space_e;

    // low nibble, register inside a channel
    typedef enum logic [3:0] {
        off_adc_data     = 4'h0,   // {pot, cur}
        off_dac_ctrl     = 4'h1,   // commanded current
        off_motor_status = 4'h2,   // amp enable / safety / fault
        off_status12     = 4'h3    // legacy amp summary, chan 0 only
    } reg_offset_e;

    typedef struct packed {
        addr_space_e space;
        logic [3:0]  reserved;
        logic [3:0]  chan;        // 0 = board level, 1..4 = axes
        reg_offset_e offset;
    } reg_addr_t;

    // one host write strobe
    typedef struct packed {
        reg_addr_t   waddr;
        logic [31:0] wdata;
        logic        wen;         // write takes effect at this edge
        logic        blk_wen;     // part of a block write
    } reg_wr_t;

    // latched feedback, laid out as the adc data register reads
    typedef struct packed {
        logic [adc_width-1:0] pot;
        logic [adc_width-1:0] cur;
    } chan_fb_t;

    // per-axis control state handed to the read side
    typedef struct packed {
        logic [dac_width-1:0] cur_cmd;
        logic                 amp_on;
        logic                 safety_dis;   // set by fault or wdog, cleared by enable
        logic                 fault_n;      // 1 -> amplifier fine
    } chan_state_t;

endpackage

//--- hdl/motor_chan_regs.sv
`timescale 1ns/1ps

module motor_chan_regs import qla_pkg::*; (
    input  logic                               sysclk,
    input  logic                               reset,
    input  reg_wr_t                            reg_wr,
    input  logic [num_chan-1:0]                amp_fault_n,    // active low fault per axis
    input  logic                               wdog_timeout,
    input  logic                               dac_busy,       // dac engine shifting out
    output chan_state_t [num_chan-1:0]         chan_state,
    output logic [num_chan-1:0][dac_width-1:0] cur_cmd,
    output logic                               dac_update,     // one cycle, dac loads cur_cmd
    output logic                               wdog_clear
);

    logic                wr_main;          // write lands in the main space
    logic [num_chan-1:0] wr_chan;          // write targets axis k+1
    logic [num_chan-1:0] wr_cur;           // current command write per axis
    logic                wr_dac;           // current command write, any axis
    logic [num_chan-1:0] amp_set;          // status write with mask bit
    logic [num_chan-1:0] amp_enable_cmd;   // status write that turns the amp on
    logic [num_chan-1:0] amp_trip;         // safety shutdown this cycle
    logic [num_chan-1:0] amp_on;
    logic [num_chan-1:0] safety_dis;
    logic                cur_cmd_req;      // dac update pending

    // ------------------------------
    // write decode
    // ------------------------------
    assign wr_main = reg_wr.wen && (reg_wr.waddr.space == space_main);

    always_comb begin
        for (int k = 0; k < num_chan; k++) begin
            wr_chan[k] = wr_main && (reg_wr.waddr.chan == 4'(k + 1));
            wr_cur[k]  = wr_chan[k] && (reg_wr.waddr.offset == off_dac_ctrl);
            amp_set[k] = wr_chan[k] && (reg_wr.waddr.offset == off_motor_status) &&
                         reg_wr.wdata[amp_en_mask_bit];
            amp_enable_cmd[k] = amp_set[k] && reg_wr.wdata[amp_en_val_bit];
            // only an amp that is on can trip
            amp_trip[k] = amp_on[k] && (!amp_fault_n[k] || wdog_timeout);
        end
    end

    assign wr_dac = |wr_cur;

    // any enable attempt kicks the watchdog, same cycle as the write
    assign wdog_clear = |amp_enable_cmd;

    // ------------------------------
    // command and amp state
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_cmd    <= '0;
            amp_on     <= '0;
            safety_dis <= '0;
        end else begin
            for (int k = 0; k < num_chan; k++) begin
                if (wr_cur[k]) begin
                    cur_cmd[k] <= reg_wr.wdata[dac_width-1:0];
                end
                if (amp_trip[k]) begin              // safety beats host enable
                    amp_on[k]     <= 1'b0;
                    safety_dis[k] <= 1'b1;
                end else if (amp_set[k]) begin
                    amp_on[k] <= reg_wr.wdata[amp_en_val_bit];
                    if (amp_enable_cmd[k]) begin
                        safety_dis[k] <= 1'b0;      // host re-enable clears sticky flag
                    end
                end
            end
        end
    end

    // ------------------------------
    // dac update request
    // ------------------------------
    // request follows blk_wen of the latest cur write, waits out dac_busy,
    // so several writes during a busy stretch give one update
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_cmd_req <= 1'b0;
            dac_update  <= 1'b0;
        end else begin
            if (wr_dac) begin
                cur_cmd_req <= reg_wr.blk_wen;
            end else if (cur_cmd_req && !dac_busy) begin
                cur_cmd_req <= 1'b0;
            end
            dac_update <= cur_cmd_req && !dac_busy;
        end
    end

    // pack state for the read mux
    always_comb begin
        for (int k = 0; k < num_chan; k++) begin
            chan_state[k].cur_cmd    = cur_cmd[k];
            chan_state[k].amp_on     = amp_on[k];
            chan_state[k].safety_dis = safety_dis[k];
            chan_state[k].fault_n    = amp_fault_n[k];   // raw, not registered
        end
    end

endmodule

//--- hdl/fb_capture.sv
`timescale 1ns/1ps

module fb_capture import qla_pkg::*; (
    input  logic                               sysclk,
    input  logic                               reset,
    input  logic [num_chan-1:0][adc_width-1:0] adc_cur,     // parallel current results
    input  logic                               cur_valid,   // one cycle strobe
    input  logic [num_chan-1:0][adc_width-1:0] adc_pot,     // parallel pot results
    input  logic                               pot_valid,   // one cycle strobe
    output chan_fb_t [num_chan-1:0]            chan_fb
);

    // last latched words, index k is axis k+1
    logic [num_chan-1:0][adc_width-1:0] cur_fb;
    logic [num_chan-1:0][adc_width-1:0] pot_fb;

    // ------------------------------
    // current feedback
    // ------------------------------
    // all four axes convert together, one strobe loads them all
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_fb <= '0;
        end else if (cur_valid) begin
            cur_fb <= adc_cur;
        end
    end

    // ------------------------------
    // pot feedback
    // ------------------------------
    // independent of the current side, pot converter runs on its own schedule
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pot_fb <= '0;
        end else if (pot_valid) begin
            pot_fb <= adc_pot;
        end
    end

    // halves may come from different samples
    always_comb begin
        for (int k = 0; k < num_chan; k++) begin
            chan_fb[k].pot = pot_fb[k];   // upper half of the read word
            chan_fb[k].cur = cur_fb[k];   // lower half
        end
    end

endmodule

//--- hdl/reg_read_mux.sv
`timescale 1ns/1ps

module reg_read_mux import qla_pkg::*; (
    input  logic                       sysclk,
    input  logic                       reset,
    input  reg_addr_t                  reg_raddr,
    input  chan_state_t [num_chan-1:0] chan_state,
    input  chan_fb_t [num_chan-1:0]    chan_fb,
    output logic [31:0]                reg_rdata     // one cycle after reg_raddr
);

    logic        rd_main;      // address in the main space
    logic        chan_hit;     // axis 1..num_chan selected
    chan_state_t sel_state;    // state of the addressed axis
    chan_fb_t    sel_fb;       // feedback of the addressed axis
    logic [31:0] motor_status;
    logic [11:0] status12;     // legacy amp summary
    logic [31:0] rd_next;

    assign rd_main = (reg_raddr.space == space_main);

    // ------------------------------
    // channel select
    // ------------------------------
    always_comb begin
        sel_state = '0;
        sel_fb    = '0;
        chan_hit  = 1'b0;
        for (int k = 0; k < num_chan; k++) begin
            if (reg_raddr.chan == 4'(k + 1)) begin
                sel_state = chan_state[k];
                sel_fb    = chan_fb[k];
                chan_hit  = 1'b1;
            end
        end
    end

    // status word, unused bits read zero
    always_comb begin
        motor_status                    = '0;
        motor_status[status_amp_on_bit] = sel_state.amp_on;
        motor_status[status_safety_bit] = sel_state.safety_dis;
        motor_status[status_fault_bit]  = sel_state.fault_n;
    end

    // {fault_n 4..1, safety_dis 4..1, amp_on 4..1}
    always_comb begin
        status12 = '0;
        for (int k = 0; k < num_chan; k++) begin
            status12[8 + k] = chan_state[k].fault_n;
            status12[4 + k] = chan_state[k].safety_dis;
            status12[k]     = chan_state[k].amp_on;
        end
    end

    // ------------------------------
    // decode and register
    // ------------------------------
    always_comb begin
        rd_next = '0;
        if (rd_main && chan_hit) begin
            case (reg_raddr.offset)
                off_adc_data:     rd_next = sel_fb;
                off_dac_ctrl:     rd_next = 32'(sel_state.cur_cmd);   // zero extend
                off_motor_status: rd_next = motor_status;
                default:          rd_next = '0;
            endcase
        end else if (rd_main && (reg_raddr.chan == 4'd0) &&
                     (reg_raddr.offset == off_status12)) begin
            rd_next = {20'd0, status12};   // board level word
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

//--- hdl/qla_core.sv
`timescale 1ns/1ps

module qla_core import qla_pkg::*; (
    input  logic                               sysclk,
    input  logic                               reset,
    // host bus
    input  reg_wr_t                            reg_wr,
    input  reg_addr_t                          reg_raddr,
    output logic [31:0]                        reg_rdata,
    // adc results, already parallel
    input  logic [num_chan-1:0][adc_width-1:0] adc_cur,
    input  logic                               cur_valid,
    input  logic [num_chan-1:0][adc_width-1:0] adc_pot,
    input  logic                               pot_valid,
    // amplifier and watchdog
    input  logic [num_chan-1:0]                amp_fault_n,
    input  logic                               wdog_timeout,
    // dac engine
    input  logic                               dac_busy,
    output logic [num_chan-1:0][dac_width-1:0] cur_cmd,
    output logic                               dac_update,
    output logic [num_chan-1:0]                amp_disable,   // 1 -> amp off
    output logic                               wdog_clear
);

    chan_state_t [num_chan-1:0] chan_state;   // command side to read mux
    chan_fb_t [num_chan-1:0]    chan_fb;      // feedback side to read mux

    // ------------------------------
    // write side and feedback
    // ------------------------------
    motor_chan_regs motor_chan_regs_inst (
        .sysclk       (sysclk),
        .reset        (reset),
        .reg_wr       (reg_wr),
        .amp_fault_n  (amp_fault_n),
        .wdog_timeout (wdog_timeout),
        .dac_busy     (dac_busy),
        .chan_state   (chan_state),
        .cur_cmd      (cur_cmd),
        .dac_update   (dac_update),
        .wdog_clear   (wdog_clear)
    );

    fb_capture fb_capture_inst (
        .sysclk    (sysclk),
        .reset     (reset),
        .adc_cur   (adc_cur),
        .cur_valid (cur_valid),
        .adc_pot   (adc_pot),
        .pot_valid (pot_valid),
        .chan_fb   (chan_fb)
    );

    // registered read path
    reg_read_mux reg_read_mux_inst (
        .sysclk     (sysclk),
        .reset      (reset),
        .reg_raddr  (reg_raddr),
        .chan_state (chan_state),
        .chan_fb    (chan_fb),
        .reg_rdata  (reg_rdata)
    );

    // disable pins are active high, follow amp_on with no extra flop
    always_comb begin
        for (int k = 0; k < num_chan; k++) begin
            amp_disable[k] = ~chan_state[k].amp_on;
        end
    end

endmodule

//--- verification/qla_core_checker.sv
`timescale 1ns/1ps

module qla_core_checker import qla_pkg::*; (
    input  logic                               sysclk,
    input  logic                               reset,
    input  reg_wr_t                            reg_wr,
    input  reg_addr_t                          reg_raddr,
    input  logic [31:0]                        reg_rdata,
    input  logic [num_chan-1:0][adc_width-1:0] adc_cur,
    input  logic                               cur_valid,
    input  logic [num_chan-1:0][adc_width-1:0] adc_pot,
    input  logic                               pot_valid,
    input  logic [num_chan-1:0]                amp_fault_n,
    input  logic                               wdog_timeout,
    input  logic                               dac_busy,
    input  logic [num_chan-1:0][dac_width-1:0] cur_cmd,
    input  logic                               dac_update,
    input  logic [num_chan-1:0]                amp_disable,
    input  logic                               wdog_clear,
    output int                                 rdata_errs,
    output int                                 dac_errs,
    output int                                 amp_errs,
    output int                                 wdog_errs,
    output int                                 dac_pulses
);

    // shadow of the DUT, index k is axis k+1
    logic [num_chan-1:0][dac_width-1:0] cmd_sh;
    logic [num_chan-1:0][adc_width-1:0] cur_sh;
    logic [num_chan-1:0][adc_width-1:0] pot_sh;
    logic [num_chan-1:0]                on_sh;
    logic [num_chan-1:0]                safe_sh;
    logic                               req_sh;     // dac update pending
    logic                               upd_sh;     // expected dac_update
    logic [31:0]                        rdata_sh;   // read word due after this edge
    reg_addr_t                          raddr_sh;   // address it came from

    // expected read word, fault bits come raw from the pins
    function automatic logic [31:0] ref_read(input reg_addr_t a,
                                             input logic [num_chan-1:0] fault_n);
        logic [31:0] word;
        int          k;
        word = '0;
        k    = int'(a.chan) - 1;
        if (a.space != space_main) begin
            word = '0;                                   // undecoded space
        end else if (k >= 0 && k < num_chan) begin
            case (a.offset)
                off_adc_data:     word = {pot_sh[k], cur_sh[k]};
                off_dac_ctrl:     word = {16'h0000, cmd_sh[k]};
                off_motor_status: word = (32'(on_sh[k]) << status_amp_on_bit) |
                                         (32'(safe_sh[k]) << status_safety_bit) |
                                         (32'(fault_n[k]) << status_fault_bit);
                default:          word = '0;
            endcase
        end else if (k == -1 && a.offset == off_status12) begin
            word[11:0] = {fault_n, safe_sh, on_sh};      // axis 4 first in each group
        end
        return word;
    endfunction

    // write strobe aimed at axis k+1, register off
    function automatic logic hits_chan(input int k, input reg_offset_e off);
        return reg_wr.wen && (reg_wr.waddr.space == space_main) &&
               (reg_wr.waddr.chan == 4'(k + 1)) && (reg_wr.waddr.offset == off);
    endfunction

    initial begin
        rdata_errs = 0;
        dac_errs   = 0;
        amp_errs   = 0;
        wdog_errs  = 0;
        dac_pulses = 0;
    end

    always @(posedge sysclk) begin : model
        logic wd_exp;
        logic upd_next;
        logic any_cmd;
        if (reset) begin
            cmd_sh   = '0;
            cur_sh   = '0;
            pot_sh   = '0;
            on_sh    = '0;
            safe_sh  = '0;
            req_sh   = 1'b0;
            upd_sh   = 1'b0;
            rdata_sh = '0;
            raddr_sh = '0;
        end else begin
            // ------------------------------
            // compare, outputs before this edge
            // ------------------------------
            if (reg_rdata !== rdata_sh) begin
                $display("Fail %0t: read of %h gave %h, expected %h",
                         $time, raddr_sh, reg_rdata, rdata_sh);
                rdata_errs++;
            end
            if (dac_update !== upd_sh) begin
                $display("Fail %0t: dac_update is %b, expected %b", $time, dac_update, upd_sh);
                dac_errs++;
            end
            if (cur_cmd !== cmd_sh) begin
                $display("Fail %0t: cur_cmd %h, expected %h", $time, cur_cmd, cmd_sh);
                dac_errs++;
            end
            dac_pulses += (dac_update === 1'b1) ? 1 : 0;
            if (amp_disable !== ~on_sh) begin
                $display("Fail %0t: amp_disable %b, expected %b", $time, amp_disable, ~on_sh);
                amp_errs++;
            end
            wd_exp = 1'b0;
            for (int k = 0; k < num_chan; k++) begin
                wd_exp |= hits_chan(k, off_motor_status);
            end
            wd_exp &= reg_wr.wdata[amp_en_mask_bit] && reg_wr.wdata[amp_en_val_bit];
            if (wdog_clear !== wd_exp) begin
                $display("Fail %0t: wdog_clear %b, expected %b", $time, wdog_clear, wd_exp);
                wdog_errs++;
            end
            rdata_sh = ref_read(reg_raddr, amp_fault_n);   // from pre-edge state
            raddr_sh = reg_raddr;

            // ------------------------------
            // shadow update
            // ------------------------------
            upd_next = req_sh && !dac_busy;
            any_cmd  = 1'b0;
            for (int k = 0; k < num_chan; k++) begin
                if (hits_chan(k, off_dac_ctrl)) begin
                    cmd_sh[k] = reg_wr.wdata[dac_width-1:0];
                    any_cmd   = 1'b1;
                end
                if (on_sh[k] && (!amp_fault_n[k] || wdog_timeout)) begin
                    on_sh[k]   = 1'b0;                   // trip wins over enable
                    safe_sh[k] = 1'b1;
                end else if (hits_chan(k, off_motor_status) &&
                             reg_wr.wdata[amp_en_mask_bit]) begin
                    on_sh[k] = reg_wr.wdata[amp_en_val_bit];
                    if (reg_wr.wdata[amp_en_val_bit]) begin
                        safe_sh[k] = 1'b0;
                    end
                end
            end
            if (any_cmd) begin
                req_sh = reg_wr.blk_wen;                 // latest write decides
            end else if (upd_next) begin
                req_sh = 1'b0;
            end
            upd_sh = upd_next;
            if (cur_valid) begin
                cur_sh = adc_cur;
            end
            if (pot_valid) begin
                pot_sh = adc_pot;
            end
        end
    end

endmodule

//--- verification/qla_core_tb.sv
`timescale 1ns/1ps

module qla_core_tb import qla_pkg::*; ();

    localparam int reset_cycles   = 8;
    localparam int sweep_cycles   = 20;     // axes 0..4, four offsets each
    localparam int n_cmd_cycles   = 200;
    localparam int n_fb_cycles    = 150;
    localparam int n_busy_runs    = 20;
    localparam int busy_run_max   = 12;     // 8 busy + 4 idle at most
    localparam int n_en_cycles    = 120;
    localparam int n_fault_cycles = 200;
    localparam int total_cycles   = 2 * (reset_cycles + sweep_cycles + 2) + n_cmd_cycles +
                                    n_fb_cycles + n_busy_runs * busy_run_max +
                                    n_en_cycles + n_fault_cycles + 8;
    localparam int timeout_cycles = 4 * total_cycles;
    localparam logic [31:0] lfsr_seed = 32'h183b;

    logic                               sysclk;
    logic                               reset;
    reg_wr_t                            reg_wr;
    reg_addr_t                          reg_raddr;
    logic [31:0]                        reg_rdata;
    logic [num_chan-1:0][adc_width-1:0] adc_cur;
    logic [num_chan-1:0][adc_width-1:0] adc_pot;
    logic                               cur_valid;
    logic                               pot_valid;
    logic [num_chan-1:0]                amp_fault_n;
    logic                               wdog_timeout;
    logic                               dac_busy;
    logic [num_chan-1:0][dac_width-1:0] cur_cmd;
    logic                               dac_update;
    logic [num_chan-1:0]                amp_disable;
    logic                               wdog_clear;
    int                                 rdata_errs;
    int                                 dac_errs;
    int                                 amp_errs;
    int                                 wdog_errs;
    int                                 dac_pulses;
    int                                 cycle_cnt;
    logic [31:0]                        lfsr_q;

    qla_core qla_core_inst (.*);
    qla_core_checker checker_inst (.*);   // compares on the rising edge

    initial sysclk = 1'b0;
    always #20 sysclk = ~sysclk;          // 40 ns period

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic take_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], take_bit()};
        end
        return v;
    endfunction

    function automatic reg_addr_t make_addr(input logic [3:0] sp, input logic [3:0] ch,
                                            input logic [3:0] off);
        return reg_addr_t'({sp, 4'h0, ch, off});
    endfunction

    // ------------------------------
    // bus helpers
    // ------------------------------
    task automatic idle_bus();
        reg_wr    = '0;        // strobes last one cycle
        cur_valid = 1'b0;
        pot_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] sp, input logic [3:0] ch, input logic [3:0] off,
                             input logic [31:0] data, input logic blk);
        reg_wr.waddr   = make_addr(sp, ch, off);
        reg_wr.wdata   = data;
        reg_wr.wen     = 1'b1;
        reg_wr.blk_wen = blk;
    endtask

    // status12 a quarter of the time, else one axis status word
    task automatic read_status();
        logic [3:0] ch;
        ch = 4'(take_bits(2) + 1);
        if (take_bits(2) == 0) begin
            reg_raddr = make_addr(4'h0, 4'h0, off_status12);
        end else begin
            reg_raddr = make_addr(4'h0, ch, off_motor_status);
        end
    endtask

    task automatic apply_reset();
        @(negedge sysclk);
        idle_bus();
        reset = 1'b1;
        repeat (reset_cycles) @(negedge sysclk);
        reset = 1'b0;
    endtask

    // every address after reset, fault pins low so the status bits stay zero too
    task automatic sweep_reads();
        amp_fault_n  = '0;
        wdog_timeout = 1'b0;
        dac_busy     = 1'b0;
        for (int ch = 0; ch <= num_chan; ch++) begin
            for (int off = 0; off < 4; off++) begin
                @(negedge sysclk);
                idle_bus();
                reg_raddr = make_addr(4'h0, 4'(ch), 4'(off));
            end
        end
    endtask

    // ------------------------------
    // test phases
    // ------------------------------
    task automatic cmd_writes();
        logic [3:0] sp;
        logic [3:0] ch;
        logic       blk;
        for (int i = 0; i < n_cmd_cycles; i++) begin
            @(negedge sysclk);
            idle_bus();
            dac_busy = take_bit();
            if (take_bit()) begin
                sp  = (take_bits(2) == 0) ? 4'(take_bits(4)) : 4'h0;   // mostly main
                ch  = 4'(take_bits(4));                               // 0, 5..15 not axes
                blk = take_bit();
                write_reg(sp, ch, off_dac_ctrl, take_bits(32), blk);
            end
            sp        = (take_bits(2) == 0) ? 4'(take_bits(4)) : 4'h0;
            ch        = 4'(take_bits(3));
            reg_raddr = make_addr(sp, ch, off_dac_ctrl);
        end
    endtask

    task automatic fb_strobes();
        logic [3:0] ch;
        for (int i = 0; i < n_fb_cycles; i++) begin
            @(negedge sysclk);
            idle_bus();
            cur_valid = (take_bits(2) == 0);
            pot_valid = (take_bits(2) == 0);
            for (int k = 0; k < num_chan; k++) begin
                adc_cur[k] = 16'(take_bits(16));   // words move without a strobe too
                adc_pot[k] = 16'(take_bits(16));
            end
            ch        = 4'(take_bits(3));
            reg_raddr = make_addr(4'h0, ch, off_adc_data);
        end
    endtask

    task automatic busy_runs();
        logic [3:0] ch;
        logic       blk;
        int         len;
        ch = 4'h1;
        for (int r = 0; r < n_busy_runs; r++) begin
            len = 1 + int'(take_bits(3));
            for (int i = 0; i < len; i++) begin
                @(negedge sysclk);
                idle_bus();
                dac_busy = 1'b1;
                if (take_bit()) begin
                    ch  = 4'(take_bits(2) + 1);
                    blk = (take_bits(2) != 0);     // plain write drops the request
                    write_reg(4'h0, ch, off_dac_ctrl, take_bits(32), blk);
                end
                reg_raddr = make_addr(4'h0, ch, off_dac_ctrl);
            end
            len = 1 + int'(take_bits(2));
            for (int i = 0; i < len; i++) begin
                @(negedge sysclk);
                idle_bus();
                dac_busy = 1'b0;
            end
        end
    endtask

    task automatic enable_writes();
        logic [3:0] ch;
        amp_fault_n  = '1;
        wdog_timeout = 1'b0;
        for (int i = 0; i < n_en_cycles; i++) begin
            @(negedge sysclk);
            idle_bus();
            dac_busy = take_bit();
            if (take_bit()) begin
                ch = 4'(take_bits(2) + 1);
                write_reg(4'h0, ch, off_motor_status, take_bits(32), 1'b0);   // random mask/val
            end
            read_status();
        end
    endtask

    task automatic fault_runs();
        logic [3:0]  ch;
        logic [31:0] data;
        for (int i = 0; i < n_fault_cycles; i++) begin
            @(negedge sysclk);
            idle_bus();
            for (int k = 0; k < num_chan; k++) begin
                amp_fault_n[k] = (take_bits(4) != 0);   // one in sixteen faults
            end
            wdog_timeout = (take_bits(5) == 0);
            if (take_bit()) begin
                ch                    = 4'(take_bits(2) + 1);
                data                  = '0;
                data[amp_en_mask_bit] = 1'b1;
                data[amp_en_val_bit]  = (take_bits(2) != 0);
                write_reg(4'h0, ch, off_motor_status, data, 1'b0);
            end
            read_status();
        end
    endtask

    // ------------------------------
    // run control
    // ------------------------------
    always @(posedge sysclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        lfsr_q       = lfsr_seed;
        cycle_cnt    = 0;
        reset        = 1'b1;
        reg_wr       = '0;
        reg_raddr    = '0;
        adc_cur      = '0;
        adc_pot      = '0;
        cur_valid    = 1'b0;
        pot_valid    = 1'b0;
        amp_fault_n  = '1;
        wdog_timeout = 1'b0;
        dac_busy     = 1'b0;
        apply_reset();
        sweep_reads();
        cmd_writes();
        fb_strobes();
        busy_runs();
        enable_writes();
        fault_runs();
        apply_reset();             // second reset with amps live
        sweep_reads();
        @(negedge sysclk);
        idle_bus();
        repeat (3) @(negedge sysclk);
        $display("errors: read %0d, dac %0d, amp %0d, wdog %0d (%0d dac updates seen)",
                 rdata_errs, dac_errs, amp_errs, wdog_errs, dac_pulses);
        if (rdata_errs + dac_errs + amp_errs + wdog_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- flist.f
hdl/qla_pkg.sv
hdl/motor_chan_regs.sv
hdl/fb_capture.sv
hdl/reg_read_mux.sv
hdl/qla_core.sv
verification/qla_core_checker.sv
verification/qla_core_tb.sv
